//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt); // sign fill
            ALU_OR:   y_o = a_i | b_i;
            ALU_AND:  y_o = a_i & b_i;
            default:  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    input  result_t         wb_res_i,
    exec_if.src             ex
);

    logic              instr_valid_q;
    logic [XLEN-1:0]   instr_q;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1_sel;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
    logic              op_b_imm;
    logic              legal;
    alu_op_e           alu_op;

    function automatic alu_op_e alu_op_from(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    ////////////////////////////////////////
    // instruction register
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        instr_q <= instr_i;
    end

    assign opcode = instr_q[6:0];
    assign rd     = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign rs1    = instr_q[19:15];
    assign rs2    = instr_q[24:20];
    assign funct7 = instr_q[31:25];

    ////////////////////////////////////////
    // decoder and immediate
    ////////////////////////////////////////
    always_comb begin
        legal    = 1'b0;
        op_b_imm = 1'b0;
        imm      = '0;
        rs1_sel  = rs1;
        alu_op   = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                legal  = (funct7 == FUNCT7_BASE) ||
                         (funct7 == FUNCT7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
                alu_op = alu_op_from(funct3, funct7 == FUNCT7_ALT);
            end
            OPC_OP_IMM: begin
                op_b_imm = 1'b1;
                imm      = {{20{instr_q[31]}}, instr_q[31:20]}; // shamt sits in imm[4:0]
                if (funct3 == F3_SLL) begin
                    legal = funct7 == FUNCT7_BASE;
                end else if (funct3 == F3_SR) begin
                    legal = funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT;
                end else begin
                    legal = 1'b1;
                end
                alu_op = alu_op_from(funct3, funct3 == F3_SR && funct7 == FUNCT7_ALT);
            end
            OPC_LUI: begin
                legal    = 1'b1;
                op_b_imm = 1'b1;
                imm      = {instr_q[31:12], 12'b0};
                rs1_sel  = '0; // x0 + imm
            end
            default: legal = 1'b0;
        endcase
    end

    regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_i       (wb_res_i),
        .rs1_addr_i (rs1_sel),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= instr_valid_q && legal && rd != '0; // x0 writes become bubbles
        end
    end

    always_ff @(posedge clk_i) begin
        ex.rd       <= rd;
        ex.rs1      <= rs1_sel;
        ex.rs2      <= rs2;
        ex.rs1_data <= rs1_data;
        ex.rs2_data <= rs2_data;
        ex.imm      <= imm;
        ex.op_b_imm <= op_b_imm;
        ex.alu_op   <= alu_op;
    end

endmodule

`default_nettype wire

//--- exec_if.sv
`timescale 1ns/10ps
`default_nettype none

interface exec_if
    import rv_pkg::*;
();
    logic              valid;     // low means bubble
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
    logic              op_b_imm;  // operand b from imm
    alu_op_e           alu_op;

    modport src (output valid, rd, rs1, rs2, rs1_data, rs2_data, imm, op_b_imm, alu_op);
    modport dst (input  valid, rd, rs1, rs2, rs1_data, rs2_data, imm, op_b_imm, alu_op);

endinterface

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    exec_if.dst     ex,
    output result_t wb_res_o
);

    result_t         mem_res; // ex/mem
    result_t         wb_res;  // mem/wb
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_y;

    // mem result wins over wb, x0 never matches since rd of a valid result is nonzero
    function automatic logic [XLEN-1:0] fwd_sel(
        input logic [REG_AW-1:0] rs,
        input logic [XLEN-1:0]   reg_val,
        input result_t           m,
        input result_t           w
    );
        if (m.valid && m.rd == rs) begin
            return m.data;
        end
        if (w.valid && w.rd == rs) begin
            return w.data;
        end
        return reg_val;
    endfunction

    ////////////////////////////////////////
    // operand select
    ////////////////////////////////////////
    assign rs1_fwd = fwd_sel(ex.rs1, ex.rs1_data, mem_res, wb_res);
    assign rs2_fwd = fwd_sel(ex.rs2, ex.rs2_data, mem_res, wb_res);
    assign op_b    = ex.op_b_imm ? ex.imm : rs2_fwd;

    alu u_alu (
        .op_i (ex.alu_op),
        .a_i  (rs1_fwd),
        .b_i  (op_b),
        .y_o  (alu_y)
    );

    ////////////////////////////////////////
    // result registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_res.valid <= 1'b0;
            wb_res.valid  <= 1'b0;
        end else begin
            mem_res.valid <= ex.valid; // bubble stays a bubble
            mem_res.rd    <= ex.rd;
            mem_res.data  <= alu_y;
            wb_res        <= mem_res;
        end
    end

    assign wb_res_o = wb_res;

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
    import rv_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  result_t           wr_i,
    input  logic [REG_AW-1:0] rs1_addr_i,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o
);

    logic [XLEN-1:0] regs [1:31]; // no storage for x0

    // write data passes straight through on a same-cycle hit
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_i.valid && wr_i.rd == addr) begin
            return wr_i.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    assign rs1_data_o = read_reg(rs1_addr_i);
    assign rs2_data_o = read_reg(rs2_addr_i);

endmodule

`default_nettype wire

//--- rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb
    import rv_pkg::*;
();

    localparam int          N_INSTR       = 2000;
    localparam int          DRAIN_TIMEOUT = 100;
    localparam logic [31:0] SEED          = 32'hd4bb_4299;

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    int          mismatch;
    int          missing;
    int          extra;
    int          pending;
    int          retired;
    int          sent;
    int          wait_cycles;
    bit          timed_out;

    rv_core_top u_rv_core_top (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    tb_checker u_checker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_i    (wb_valid_o),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .mismatch_o    (mismatch),
        .missing_o     (missing),
        .extra_o       (extra),
        .pending_o     (pending),
        .retired_o     (retired)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [4:0] pick_reg();
        if ($urandom_range(9) != 0) begin
            return 5'($urandom_range(7)); // mostly x0..x7
        end
        return 5'($urandom_range(31));
    endfunction

    function automatic logic [11:0] pick_imm12();
        case ($urandom_range(7))
            0:       return 12'h7ff;
            1:       return 12'h800;
            2:       return 12'hfff;
            default: return 12'($urandom());
        endcase
    endfunction

    function automatic logic [31:0] make_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        int unsigned kind;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'($urandom_range(7));
        kind  = $urandom_range(99);
        f7    = ($urandom_range(1) == 1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        imm12 = pick_imm12();
        if (kind < 40) begin
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        end else if (kind < 75) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12[11:5] = f7; // shamt forms
            end
            return {imm12, rs1, f3, rd, OPC_OP_IMM};
        end else if (kind < 88) begin
            return {20'($urandom()), rd, OPC_LUI};
        end else if (kind < 94) begin
            f7 = ($urandom_range(1) == 1) ? 7'h20 : (7'($urandom()) | 7'h01); // odd funct7
            return {f7, rs2, rs1, f3, rd, ($urandom_range(1) == 1) ? OPC_OP : OPC_OP_IMM};
        end
        return $urandom(); // mostly not a kept opcode
    endfunction

    task automatic finish_run(input bit failed);
        $display("summary: %0d retired, %0d mismatches, %0d missing, %0d unexpected",
                 retired, mismatch, missing, extra);
        if (failed || mismatch != 0 || missing != 0 || extra != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        sent    = 0;
        while (sent < N_INSTR) begin
            @(posedge clk_i);
            #1;
            if ($urandom_range(99) < 15) begin
                instr_valid_i = 1'b0;
                instr_i       = $urandom(); // junk while idle
            end else begin
                instr_valid_i = 1'b1;
                instr_i       = make_instr();
                sent++;
            end
        end
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;

        ////////////////////////////////////////
        // drain the pipeline
        ////////////////////////////////////////
        wait_cycles = 0;
        while (pending != 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            wait_cycles++;
        end
        timed_out = pending != 0;
        if (timed_out) begin
            $display("timeout: %0d writebacks still pending after %0d cycles",
                     pending, DRAIN_TIMEOUT);
        end
        repeat (5) @(posedge clk_i); // quiet window for stray writebacks
        #1;
        finish_run(timed_out);
    end

endmodule

`default_nettype wire

//--- rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top
    import rv_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              instr_valid_i,
    input  logic [XLEN-1:0]   instr_i,
    output logic              wb_valid_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o
);

    result_t wb_res;

    exec_if ex_bus ();

    decode_stage u_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_res_i      (wb_res),   // register write and bypass
        .ex            (ex_bus.src)
    );

    execute_stage u_execute (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ex       (ex_bus.dst),
        .wb_res_o (wb_res)
    );

    assign wb_valid_o = wb_res.valid;
    assign wb_rd_o    = wb_res.rd;
    assign wb_data_o  = wb_res.data;

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // alu operation select, add must stay at zero
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    ////////////////////////////////////////
    // opcodes and funct fields
    ////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub / sra

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra share it
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // one retired result, 38 bits
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } result_t;

endpackage

`default_nettype wire

//--- sources.f
rv_pkg.sv
exec_if.sv
regfile.sv
alu.sv
decode_stage.sv
execute_stage.sv
rv_core_top.sv
tb_checker.sv
rv_core_tb.sv

//--- tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_checker
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic        wb_valid_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i,
    output int          mismatch_o,
    output int          missing_o,
    output int          extra_o,
    output int          pending_o,
    output int          retired_o
);

    typedef struct packed {
        logic [31:0] due;   // edge that loads the writeback
        logic [4:0]  rd;
        logic [31:0] data;
    } expect_t;

    expect_t     exp_q[$];
    logic [31:0] model_rf [32];
    logic [31:0] cycle;

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input bit alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] sra_full;
        sra_full = {{32{a[31]}}, a} >> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra_full[31:0] : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // 1 when the word is a kept instruction with nonzero rd
    function automatic bit predict(input logic [31:0] w, output logic [31:0] res);
        logic [2:0] f3;
        logic [6:0] f7;
        bit         ok;
        bit         alt;
        f3  = w[14:12];
        f7  = w[31:25];
        ok  = 1'b0;
        res = '0;
        if (w[6:0] == OPC_LUI) begin
            ok  = 1'b1;
            res = {w[31:12], 12'h000};
        end else if (w[6:0] == OPC_OP) begin
            alt = f7 == 7'h20;
            ok  = f7 == 7'h00 || (alt && (f3 == 3'd0 || f3 == 3'd5));
            res = alu_model(f3, alt, model_rf[w[19:15]], model_rf[w[24:20]]);
        end else if (w[6:0] == OPC_OP_IMM) begin
            alt = f3 == 3'd5 && f7 == 7'h20; // srai only
            ok  = (f3 == 3'd1) ? f7 == 7'h00 :
                  (f3 == 3'd5) ? (f7 == 7'h00 || alt) : 1'b1;
            res = alu_model(f3, alt, model_rf[w[19:15]], {{20{w[31]}}, w[31:20]});
        end
        return ok && w[11:7] != 5'd0;
    endfunction

    task automatic check_writeback();
        expect_t head;
        if (wb_valid_i) begin
            if (exp_q.size() == 0 || exp_q[0].due != cycle - 1) begin
                extra_o++;
                $display("ERROR at %0t: unexpected writeback x%0d = %08h",
                         $time, wb_rd_i, wb_data_i);
            end else begin
                head = exp_q.pop_front();
                retired_o++;
                if (wb_rd_i != head.rd || wb_data_i != head.data) begin
                    mismatch_o++;
                    $display("ERROR at %0t: expected x%0d = %08h, got x%0d = %08h",
                             $time, head.rd, head.data, wb_rd_i, wb_data_i);
                end
            end
        end
        while (exp_q.size() != 0 && exp_q[0].due <= cycle - 1) begin
            head = exp_q.pop_front();
            missing_o++;
            $display("ERROR at %0t: no writeback for x%0d = %08h", $time, head.rd, head.data);
        end
    endtask

    ////////////////////////////////////////
    // sample on every edge, model in issue order
    ////////////////////////////////////////
    always @(posedge clk_i or negedge rst_n_i) begin
        logic [31:0] res;
        if (!rst_n_i) begin
            cycle = 0;
            exp_q.delete();
            for (int i = 0; i < 32; i++) begin
                model_rf[i] = '0;
            end
        end else begin
            cycle = cycle + 1;
            check_writeback();
            if (instr_valid_i && predict(instr_i, res)) begin
                model_rf[instr_i[11:7]] = res;
                exp_q.push_back('{due: cycle + 3, rd: instr_i[11:7], data: res});
            end
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire
